// File: Makefile
# Verilator build and run of the graphics scan testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f flist.f --top-module tb_graphics_scan -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_graphics_scan); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: design/fb_address_map.sv
/* screen coordinate to frame-buffer address mapping and write strobe */
`timescale 1ns/1ps
`include "pacgfx_settings.svh"

module fb_address_map (
    input  pacgfx_pkg::coord_t      xpos,
    input  pacgfx_pkg::coord_t      ypos,
    input  logic                    scan_active,
    output pacgfx_pkg::fb_addr_t    address,
    output logic                    wr_valid
);

    logic                   in_maze;
    logic                   in_score;
    pacgfx_pkg::fb_addr_t   maze_row;
    pacgfx_pkg::fb_addr_t   score_row;

    assign in_maze = (ypos >= 9'(`MAZE_Y0)) && (ypos < 9'(`MAZE_Y0 + `MAZE_H));

    assign in_score = (ypos >= 9'(`SCORE_Y0)) && (ypos < 9'(`SCORE_Y0 + `SCORE_H))
                   && (xpos >= 9'(`SCORE_X0)) && (xpos < 9'(`SCORE_X0 + `SCORE_W));

    assign maze_row  = 16'(ypos) - 16'(`MAZE_Y0);
    assign score_row = 16'(ypos) - 16'(`SCORE_Y0);

    // maze band wins over the score strip
    always_comb begin
        if (in_maze) begin
            address = 16'(xpos) + maze_row * 16'(`SCREEN_W);
        end else if (in_score) begin
            // score x keeps its screen offset, as the reader side expects
            address = 16'(`SCORE_ADDR0) + 16'(xpos) + score_row * 16'(`SCORE_W);
        end else begin
            address = 16'(`ADDR_NONE);
        end
    end

    assign wr_valid = scan_active && (address != 16'(`ADDR_NONE));

endmodule

// File: design/graphics_scan_top.sv
/* scan side of the renderer: position latch, scan FSM,
   address map and layer merge */
`timescale 1ns/1ps
`include "pacgfx_settings.svh"

module graphics_scan_top (
    input  logic                    vgaclk,
    input  logic                    rst,
    input  logic [9:0]              hc,
    input  logic [9:0]              vc,
    input  logic                    scanall,
    input  logic                    buffer_sel,
    input  pacgfx_pkg::coord_t      sprite_x_in [`NUM_SPRITES],
    input  pacgfx_pkg::coord_t      sprite_y_in [`NUM_SPRITES],
    input  pacgfx_pkg::color_t      ghost_color [`NUM_SPRITES - 1],
    input  pacgfx_pkg::color_t      pacman_color,
    input  pacgfx_pkg::color_t      maze_color,
    input  pacgfx_pkg::color_t      score_color,
    output pacgfx_pkg::coord_t      xpos,
    output pacgfx_pkg::coord_t      ypos,
    output pacgfx_pkg::fb_addr_t    address,
    output logic                    wr_valid,
    output pacgfx_pkg::color_t      color
);

    logic                   frame_end;
    logic                   scan_active;
    pacgfx_pkg::coord_t     cur_x [`NUM_SPRITES];
    pacgfx_pkg::coord_t     cur_y [`NUM_SPRITES];
    pacgfx_pkg::coord_t     prev_x [`NUM_SPRITES];
    pacgfx_pkg::coord_t     prev_y [`NUM_SPRITES];

    sprite_position_regs pos_regs_i (
        .vgaclk      (vgaclk),
        .rst         (rst),
        .frame_end   (frame_end),
        .buffer_sel  (buffer_sel),
        .sprite_x_in (sprite_x_in),
        .sprite_y_in (sprite_y_in),
        .cur_x       (cur_x),
        .cur_y       (cur_y),
        .prev_x      (prev_x),
        .prev_y      (prev_y)
    );

    scan_sequencer seq_i (
        .vgaclk      (vgaclk),
        .rst         (rst),
        .hc          (hc),
        .vc          (vc),
        .scanall     (scanall),
        .cur_x       (cur_x),
        .cur_y       (cur_y),
        .prev_x      (prev_x),
        .prev_y      (prev_y),
        .xpos        (xpos),
        .ypos        (ypos),
        .scan_active (scan_active),
        .frame_end   (frame_end)
    );

    fb_address_map addr_map_i (
        .xpos        (xpos),
        .ypos        (ypos),
        .scan_active (scan_active),
        .address     (address),
        .wr_valid    (wr_valid)
    );

    layer_priority_mux layer_mux_i (
        .ghost_color  (ghost_color),
        .pacman_color (pacman_color),
        .maze_color   (maze_color),
        .score_color  (score_color),
        .color        (color)
    );

endmodule

// File: design/layer_priority_mux.sv
/* layer merge, first non-black color wins */
`timescale 1ns/1ps
`include "pacgfx_settings.svh"

module layer_priority_mux (
    input  pacgfx_pkg::color_t  ghost_color [`NUM_SPRITES - 1],
    input  pacgfx_pkg::color_t  pacman_color,
    input  pacgfx_pkg::color_t  maze_color,
    input  pacgfx_pkg::color_t  score_color,
    output pacgfx_pkg::color_t  color
);

    // ghosts on top, blinky first, then pacman, maze and score
    always_comb begin
        if (ghost_color[0] != pacgfx_pkg::COLOR_BLACK) begin
            color = ghost_color[0];
        end else if (ghost_color[1] != pacgfx_pkg::COLOR_BLACK) begin
            color = ghost_color[1];
        end else if (ghost_color[2] != pacgfx_pkg::COLOR_BLACK) begin
            color = ghost_color[2];
        end else if (ghost_color[3] != pacgfx_pkg::COLOR_BLACK) begin
            color = ghost_color[3];
        end else if (pacman_color != pacgfx_pkg::COLOR_BLACK) begin
            color = pacman_color;
        end else if (maze_color != pacgfx_pkg::COLOR_BLACK) begin
            color = maze_color;
        end else if (score_color != pacgfx_pkg::COLOR_BLACK) begin
            color = score_color;
        end else begin
            color = pacgfx_pkg::COLOR_BLACK;
        end
    end

endmodule

// File: design/pacgfx_pkg.sv
/* coordinate, color and address types, scan state and sprite index enums */
package pacgfx_pkg;

    // one screen coordinate, wide enough for 0..319
    typedef logic [8:0] coord_t;

    // RGB 3-3-2 pixel
    typedef logic [7:0] color_t;

    // black means transparent in the layer merge
    localparam color_t COLOR_BLACK = 8'h00;

    typedef logic [15:0] fb_addr_t;

    typedef enum logic [3:0] {
        SCAN_FULL0      = 4'd0,
        SCAN_FULL1      = 4'd1,
        SCAN_SPRITE_NEW = 4'd2,
        SCAN_SPRITE_OLD = 4'd3,
        SCAN_PELLETS    = 4'd4,
        SCAN_SCORE      = 4'd5,
        SCAN_IDLE       = 4'd15
    } scan_state_t;

    // also the sweep order of the sprites
    typedef enum logic [2:0] {
        PACMAN = 3'd0,
        BLINKY = 3'd1,
        PINKY  = 3'd2,
        INKY   = 3'd3,
        CLYDE  = 3'd4
    } sprite_id_t;

endpackage

// File: design/pacgfx_settings.svh
/* screen, VGA timing, sweep, pellet and score geometry constants,
   plus frame-buffer address constants for the scan side of the renderer */
`ifndef PACGFX_SETTINGS_SVH
`define PACGFX_SETTINGS_SVH

// rotated screen, one pixel per 2x2 VGA pixels
`define SCREEN_W        240
`define SCREEN_H        320

// visible VGA area and the counter values at the last pixel of a frame
`define VGA_VIS_W       640
`define VGA_VIS_H       480
`define VGA_LAST_HC     799
`define VGA_LAST_VC     524

// sprite box is 16x16, centered on the sprite position
`define SPRITE_HALF     7
`define SWEEP_LAST      255

// power pellet block corners
`define PELLET_NEAR     8
`define PELLET_FAR_X    224
`define PELLET_TOP_Y    56
`define PELLET_BOT_Y    224

// score strip, seven 8x8 digits
`define SCORE_X0        8
`define SCORE_Y0        8
`define SCORE_W         56
`define SCORE_H         8
`define SCORE_LAST      448

// maze band held in the frame buffer
`define MAZE_Y0         24
`define MAZE_H          264

// frame-buffer addresses
`define SCORE_ADDR0     63360
`define ADDR_NONE       65535

`define NUM_SPRITES     5

`endif

// File: design/scan_sequencer.sv
/* scan FSM and sweep counter producing the coordinate to redraw each cycle,
   plus the frame-end pulse from the VGA counters */
`timescale 1ns/1ps
`include "pacgfx_settings.svh"

module scan_sequencer (
    input  logic                vgaclk,
    input  logic                rst,
    input  logic [9:0]          hc,
    input  logic [9:0]          vc,
    input  logic                scanall,
    input  pacgfx_pkg::coord_t  cur_x [`NUM_SPRITES],
    input  pacgfx_pkg::coord_t  cur_y [`NUM_SPRITES],
    input  pacgfx_pkg::coord_t  prev_x [`NUM_SPRITES],
    input  pacgfx_pkg::coord_t  prev_y [`NUM_SPRITES],
    output pacgfx_pkg::coord_t  xpos,
    output pacgfx_pkg::coord_t  ypos,
    output logic                scan_active,
    output logic                frame_end
);

    pacgfx_pkg::scan_state_t    state;
    pacgfx_pkg::sprite_id_t     sprite;
    logic [8:0]                 scan_count;

    pacgfx_pkg::coord_t         base_x;
    pacgfx_pkg::coord_t         base_y;
    pacgfx_pkg::coord_t         pellet_x;
    pacgfx_pkg::coord_t         pellet_y;

    assign frame_end = (hc == `VGA_LAST_HC) && (vc == `VGA_LAST_VC);
    assign scan_active = (state != pacgfx_pkg::SCAN_IDLE);

    always_ff @(posedge vgaclk) begin
        if (rst) begin
            state      <= pacgfx_pkg::SCAN_FULL0;
            sprite     <= pacgfx_pkg::PACMAN;
            scan_count <= '0;
        end else begin
            case (state)
                pacgfx_pkg::SCAN_FULL0: begin
                    scan_count <= '0;
                    if (frame_end) begin
                        state <= pacgfx_pkg::SCAN_FULL1;
                    end
                end

                pacgfx_pkg::SCAN_FULL1, pacgfx_pkg::SCAN_IDLE: begin
                    scan_count <= '0;
                    sprite     <= pacgfx_pkg::PACMAN;
                    if (frame_end) begin
                        if (scanall) begin
                            state <= pacgfx_pkg::SCAN_FULL0;
                        end else begin
                            state <= pacgfx_pkg::SCAN_SPRITE_NEW;
                        end
                    end
                end

                pacgfx_pkg::SCAN_SPRITE_NEW: begin
                    if (scan_count == 9'(`SWEEP_LAST)) begin
                        scan_count <= '0;
                        state      <= pacgfx_pkg::SCAN_SPRITE_OLD;
                    end else begin
                        scan_count <= scan_count + 9'd1;
                    end
                end

                pacgfx_pkg::SCAN_SPRITE_OLD: begin
                    if (scan_count == 9'(`SWEEP_LAST)) begin
                        scan_count <= '0;
                        if (sprite == pacgfx_pkg::CLYDE) begin
                            state <= pacgfx_pkg::SCAN_PELLETS;
                        end else begin
                            sprite <= pacgfx_pkg::sprite_id_t'(sprite + 3'd1);
                            state  <= pacgfx_pkg::SCAN_SPRITE_NEW;
                        end
                    end else begin
                        scan_count <= scan_count + 9'd1;
                    end
                end

                pacgfx_pkg::SCAN_PELLETS: begin
                    if (scan_count == 9'(`SWEEP_LAST)) begin
                        scan_count <= '0;
                        state      <= pacgfx_pkg::SCAN_SCORE;
                    end else begin
                        scan_count <= scan_count + 9'd1;
                    end
                end

                pacgfx_pkg::SCAN_SCORE: begin
                    if (scan_count == 9'(`SCORE_LAST)) begin
                        scan_count <= '0;
                        state      <= pacgfx_pkg::SCAN_IDLE;
                    end else begin
                        scan_count <= scan_count + 9'd1;
                    end
                end

                default: begin
                    scan_count <= '0;
                    state      <= pacgfx_pkg::SCAN_FULL0;
                end
            endcase
        end
    end

    // box center for the sprite being swept
    always_comb begin
        if (state == pacgfx_pkg::SCAN_SPRITE_OLD) begin
            base_x = prev_x[sprite];
            base_y = prev_y[sprite];
        end else begin
            base_x = cur_x[sprite];
            base_y = cur_y[sprite];
        end
    end

    // count bit 6 picks the right column, bit 7 the lower row
    assign pellet_x = scan_count[6] ? 9'(`PELLET_FAR_X) : 9'(`PELLET_NEAR);
    assign pellet_y = scan_count[7] ? 9'(`PELLET_BOT_Y) : 9'(`PELLET_TOP_Y);

    always_comb begin
        xpos = '0;
        ypos = '0;
        case (state)
            pacgfx_pkg::SCAN_FULL0, pacgfx_pkg::SCAN_FULL1: begin
                // screen is rotated, vc runs along x in reverse
                if (vc < `VGA_VIS_H) begin
                    xpos = 9'(`SCREEN_W - 1) - vc[9:1];
                    if (hc < `VGA_VIS_W) begin
                        ypos = hc[9:1];
                    end else begin
                        ypos = 9'(`SCREEN_H - 1);
                    end
                end
            end

            pacgfx_pkg::SCAN_SPRITE_NEW, pacgfx_pkg::SCAN_SPRITE_OLD: begin
                xpos = base_x - 9'(`SPRITE_HALF) + {5'd0, scan_count[3:0]};
                ypos = base_y - 9'(`SPRITE_HALF) + {5'd0, scan_count[7:4]};
            end

            pacgfx_pkg::SCAN_PELLETS: begin
                xpos = pellet_x + {6'd0, scan_count[2:0]};
                ypos = pellet_y + {6'd0, scan_count[5:3]};
            end

            pacgfx_pkg::SCAN_SCORE: begin
                xpos = 9'(`SCORE_X0) + (scan_count % 9'(`SCORE_W));
                ypos = 9'(`SCORE_Y0) + (scan_count / 9'(`SCORE_W));
            end

            default: begin
                xpos = '0;
                ypos = '0;
            end
        endcase
    end

endmodule

// File: design/sprite_position_regs.sv
/* per-frame sprite position latch with two banks of previous positions,
   one bank per half of the ping-pong frame buffer */
`timescale 1ns/1ps
`include "pacgfx_settings.svh"

module sprite_position_regs (
    input  logic                vgaclk,
    input  logic                rst,
    input  logic                frame_end,
    input  logic                buffer_sel,
    input  pacgfx_pkg::coord_t  sprite_x_in [`NUM_SPRITES],
    input  pacgfx_pkg::coord_t  sprite_y_in [`NUM_SPRITES],
    output pacgfx_pkg::coord_t  cur_x [`NUM_SPRITES],
    output pacgfx_pkg::coord_t  cur_y [`NUM_SPRITES],
    output pacgfx_pkg::coord_t  prev_x [`NUM_SPRITES],
    output pacgfx_pkg::coord_t  prev_y [`NUM_SPRITES]
);

    pacgfx_pkg::coord_t bank0_x [`NUM_SPRITES];
    pacgfx_pkg::coord_t bank0_y [`NUM_SPRITES];
    pacgfx_pkg::coord_t bank1_x [`NUM_SPRITES];
    pacgfx_pkg::coord_t bank1_y [`NUM_SPRITES];

    // sampled once per frame so a sweep never sees a moving sprite
    always_ff @(posedge vgaclk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_SPRITES; i++) begin
                cur_x[i]   <= '0;
                cur_y[i]   <= '0;
                bank0_x[i] <= '0;
                bank0_y[i] <= '0;
                bank1_x[i] <= '0;
                bank1_y[i] <= '0;
            end
        end else if (frame_end) begin
            for (int i = 0; i < `NUM_SPRITES; i++) begin
                cur_x[i] <= sprite_x_in[i];
                cur_y[i] <= sprite_y_in[i];
                // old position goes to the bank of the half being written
                if (buffer_sel) begin
                    bank0_x[i] <= cur_x[i];
                    bank0_y[i] <= cur_y[i];
                end else begin
                    bank1_x[i] <= cur_x[i];
                    bank1_y[i] <= cur_y[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_SPRITES; i++) begin
            if (buffer_sel) begin
                prev_x[i] = bank0_x[i];
                prev_y[i] = bank0_y[i];
            end else begin
                prev_x[i] = bank1_x[i];
                prev_y[i] = bank1_y[i];
            end
        end
    end

endmodule

// File: flist.f
+incdir+design
design/pacgfx_pkg.sv
design/sprite_position_regs.sv
design/scan_sequencer.sv
design/fb_address_map.sv
design/layer_priority_mux.sv
design/graphics_scan_top.sv
tb/tb_clock_gen.sv
tb/tb_graphics_scan.sv

// File: tb/tb_clock_gen.sv
/* testbench clock at a 40 ns period and a 3-cycle reset */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic vgaclk,
    output logic rst
);

    initial begin
        vgaclk = 1'b0;
        forever begin
            #20 vgaclk = ~vgaclk;
        end
    end

    // released 2 ns after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge vgaclk);
        #2 rst = 1'b0;
    end

endmodule

// File: tb/tb_graphics_scan.sv
/* directed tests of the scan side: full-screen mapping, sprite, pellet and
   score sweeps, ping-pong position banks, layer priority */
`timescale 1ns/1ps
`include "pacgfx_settings.svh"

module tb_graphics_scan;

    // six full scan sequences plus margin
    localparam int WATCHDOG_CYCLES = 6 * 3265 + 2000;

    logic                   vgaclk;
    logic                   rst;
    logic [9:0]             hc;
    logic [9:0]             vc;
    logic                   scanall;
    logic                   buffer_sel;
    pacgfx_pkg::coord_t     sprite_x_in [`NUM_SPRITES];
    pacgfx_pkg::coord_t     sprite_y_in [`NUM_SPRITES];
    pacgfx_pkg::color_t     ghost_color [`NUM_SPRITES - 1];
    pacgfx_pkg::color_t     pacman_color;
    pacgfx_pkg::color_t     maze_color;
    pacgfx_pkg::color_t     score_color;
    pacgfx_pkg::coord_t     xpos;
    pacgfx_pkg::coord_t     ypos;
    pacgfx_pkg::fb_addr_t   address;
    logic                   wr_valid;
    pacgfx_pkg::color_t     color;

    logic [31:0] lfsr = 32'h5be1_13db;
    int errors = 0;
    int tests_run = 0;
    int tests_passed = 0;

    // reference copy of the position registers, bank 0 and bank 1
    int model_cur_x [`NUM_SPRITES];
    int model_cur_y [`NUM_SPRITES];
    int model_bank_x [2][`NUM_SPRITES];
    int model_bank_y [2][`NUM_SPRITES];

    tb_clock_gen clk_gen_i (.vgaclk(vgaclk), .rst(rst));

    graphics_scan_top dut_i (.*);

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int unsigned rand_bits(input int n);
        int unsigned value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            value = (value << 1) | 32'(fb);
        end
        return value;
    endfunction

    // maze band first, then the score strip
    function automatic int expected_address(input int x, input int y);
        if (y >= `MAZE_Y0 && y < `MAZE_Y0 + `MAZE_H) begin
            return x + (y - `MAZE_Y0) * `SCREEN_W;
        end
        if (y >= `SCORE_Y0 && y < `SCORE_Y0 + `SCORE_H
                && x >= `SCORE_X0 && x < `SCORE_X0 + `SCORE_W) begin
            return `SCORE_ADDR0 + x + (y - `SCORE_Y0) * `SCORE_W;
        end
        return `ADDR_NONE;
    endfunction

    task automatic next_cycle;
        @(posedge vgaclk);
        #2;
    endtask

    // sample at the falling edge, then move on to the next drive point
    task automatic expect_cycle(input int ex, input int ey, input bit active);
        int ea;
        bit ev;
        ea = expected_address(ex, ey);
        ev = active && (ea != `ADDR_NONE);
        @(negedge vgaclk);
        if (int'(xpos) != ex || int'(ypos) != ey) begin
            errors++;
            $display("Fail at %0t: coordinate (%0d,%0d), expected (%0d,%0d)",
                     $time, xpos, ypos, ex, ey);
        end
        if (int'(address) != ea || wr_valid != ev) begin
            errors++;
            $display("Fail at %0t: address %0d wr_valid %0b, expected %0d and %0b",
                     $time, address, wr_valid, ea, ev);
        end
        next_cycle();
    endtask

    // one cycle at the last pixel, new positions latched in the model too
    task automatic frame_end_pulse(input bit all);
        int bank;
        bank = buffer_sel ? 0 : 1;
        scanall = all;
        hc = 10'(`VGA_LAST_HC);
        vc = 10'(`VGA_LAST_VC);
        for (int i = 0; i < `NUM_SPRITES; i++) begin
            sprite_x_in[i] = 9'(rand_bits(9) % `SCREEN_W);
            sprite_y_in[i] = 9'(rand_bits(9) % `SCREEN_H);
            model_bank_x[bank][i] = model_cur_x[i];
            model_bank_y[bank][i] = model_cur_y[i];
            model_cur_x[i] = int'(sprite_x_in[i]);
            model_cur_y[i] = int'(sprite_y_in[i]);
        end
        next_cycle();
        hc = 10'd0;
        vc = 10'd0;
        scanall = 1'b0;
    endtask

    // random counters inside one window, checked against the full-screen rule
    task automatic full_screen_checks(input int n, input int h0, input int hspan,
                                      input int v0, input int vspan);
        int h;
        int v;
        int ex;
        int ey;
        for (int i = 0; i < n; i++) begin
            h = h0 + int'(rand_bits(10) % hspan);
            v = v0 + int'(rand_bits(10) % vspan);
            hc = 10'(h);
            vc = 10'(v);
            ex = (v < `VGA_VIS_H) ? `SCREEN_W - 1 - v / 2 : 0;
            ey = (v >= `VGA_VIS_H) ? 0 : (h < `VGA_VIS_W) ? h / 2 : `SCREEN_H - 1;
            expect_cycle(ex, ey, 1'b1);
        end
    endtask

    // new box then old box per sprite, coordinates wrap at 9 bits
    task automatic check_sprite_sweeps;
        int bank;
        int bx;
        int by;
        bank = buffer_sel ? 0 : 1;
        for (int s = 0; s < `NUM_SPRITES; s++) begin
            for (int old = 0; old < 2; old++) begin
                bx = (old == 1) ? model_bank_x[bank][s] : model_cur_x[s];
                by = (old == 1) ? model_bank_y[bank][s] : model_cur_y[s];
                for (int c = 0; c <= `SWEEP_LAST; c++) begin
                    expect_cycle((bx - `SPRITE_HALF + c % 16) & 511,
                                 (by - `SPRITE_HALF + c / 16) & 511, 1'b1);
                end
            end
        end
    endtask

    task automatic check_pellet_score;
        // quadrants in order top left, top right, bottom left, bottom right
        for (int c = 0; c <= `SWEEP_LAST; c++) begin
            expect_cycle(((c / 64) % 2 == 1 ? `PELLET_FAR_X : `PELLET_NEAR) + c % 8,
                         (c / 64 >= 2 ? `PELLET_BOT_Y : `PELLET_TOP_Y) + (c / 8) % 8, 1'b1);
        end
        for (int c = 0; c <= `SCORE_LAST; c++) begin
            expect_cycle(`SCORE_X0 + c % `SCORE_W, `SCORE_Y0 + c / `SCORE_W, 1'b1);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            tests_passed++;
            $display("%-26s passed", name);
        end else begin
            $display("%-26s failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_full_screen;
        int start_errors;
        start_errors = errors;
        full_screen_checks(200, 0, `VGA_VIS_W, 0, `VGA_VIS_H);
        // horizontal blank, then vertical blank short of the last pixel
        full_screen_checks(40, `VGA_VIS_W, `VGA_LAST_HC + 1 - `VGA_VIS_W, 0, `VGA_VIS_H);
        full_screen_checks(40, 0, `VGA_LAST_HC + 1, `VGA_VIS_H, `VGA_LAST_VC - `VGA_VIS_H);
        // second full frame still follows the counters
        frame_end_pulse(1'b0);
        full_screen_checks(50, 0, `VGA_LAST_HC + 1, 0, `VGA_LAST_VC);
        report_test("full screen mapping", start_errors);
    endtask

    task automatic test_sprite_sweeps;
        int start_errors;
        start_errors = errors;
        // scanall low here, so the sweep starts right after this edge
        frame_end_pulse(1'b0);
        check_sprite_sweeps();
        report_test("sprite sweeps", start_errors);
    endtask

    task automatic test_pellet_score;
        int start_errors;
        start_errors = errors;
        check_pellet_score();
        // idle ignores the counters until the next frame end
        for (int i = 0; i < 40; i++) begin
            hc = 10'(rand_bits(10) % (`VGA_LAST_HC + 1));
            vc = 10'(rand_bits(9) % `VGA_VIS_H);
            expect_cycle(0, 0, 1'b0);
        end
        frame_end_pulse(1'b1);
        full_screen_checks(40, 0, `VGA_VIS_W, 0, `VGA_VIS_H);
        report_test("pellet and score sweeps", start_errors);
    endtask

    task automatic test_ping_pong;
        int start_errors;
        start_errors = errors;
        buffer_sel = 1'b1;
        frame_end_pulse(1'b0);
        full_screen_checks(20, 0, `VGA_VIS_W, 0, `VGA_VIS_H);
        buffer_sel = 1'b0;
        frame_end_pulse(1'b0);
        // select flips after the edge so the old box comes from the other bank
        buffer_sel = 1'b1;
        check_sprite_sweeps();
        check_pellet_score();
        frame_end_pulse(1'b0);
        buffer_sel = 1'b0;
        check_sprite_sweeps();
        report_test("ping-pong position banks", start_errors);
    endtask

    task automatic test_layer_priority;
        int start_errors;
        int layers [7];
        int expected;
        start_errors = errors;
        for (int i = 0; i < 300; i++) begin
            expected = 0;
            // blinky to clyde, pacman, maze, score; every 64th draw all black
            for (int k = 0; k < 7; k++) begin
                layers[k] = int'(rand_bits(8));
                if (rand_bits(1) == 1 || i % 64 == 0) begin
                    layers[k] = 0;
                end
                if (expected == 0) begin
                    expected = layers[k];
                end
            end
            for (int k = 0; k < 4; k++) begin
                ghost_color[k] = 8'(layers[k]);
            end
            pacman_color = 8'(layers[4]);
            maze_color = 8'(layers[5]);
            score_color = 8'(layers[6]);
            @(negedge vgaclk);
            if (int'(color) != expected) begin
                errors++;
                $display("Fail at %0t: color %02h, expected %02h", $time, color, expected);
            end
            next_cycle();
        end
        report_test("layer priority", start_errors);
    endtask

    initial begin
        hc = 10'd0;
        vc = 10'd0;
        scanall = 1'b0;
        buffer_sel = 1'b0;
        sprite_x_in = '{default: '0};
        sprite_y_in = '{default: '0};
        ghost_color = '{default: '0};
        pacman_color = '0;
        maze_color = '0;
        score_color = '0;
        @(negedge rst);
        test_full_screen();
        test_sprite_sweeps();
        test_pellet_score();
        test_ping_pong();
        test_layer_priority();
        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 40);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule
